//--- src.f
hdl/trigger_pkg.sv
hdl/acq_req_if.sv
hdl/trigger_stamper.sv
hdl/acq_controller.sv
hdl/event_fifo.sv
hdl/event_matcher.sv
hdl/trigger_top.sv
sim/tb_clock_gen.sv
sim/trigger_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= trigger_top_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' src.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) src.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f src.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/trigger_top_tb.sv
// assumes a nonzero chan_en per trigger so chan_enable shows the controller busy; no timestamp reset
`timescale 1ns/1ps
`default_nettype none

module trigger_top_tb;
    import trigger_pkg::*;

    localparam int RUN_CYCLES = 3000;
    localparam int WAIT_LIMIT = 4000;

    logic ttc_clk, arst_n;
    logic ttc_trigger, rst_trigger_num, rst_trigger_timestamp;
    trig_type_t trig_type;
    chan_mask_t chan_en, chan_dones, chan_enable, chan_trig;
    logic [DELAY_W-1:0] trig_delay;
    logic readout_ready, readout_done, initiate_readout;
    trig_num_t ttc_event_num, ttc_trig_num;
    trig_type_t ttc_trig_type;
    timestamp_t ttc_trig_timestamp;
    logic trig_fifo_full, acq_fifo_full, error_trig_rate, error_trig_num, error_trig_type;

    integer seed = 32'h262b;
    int value_errs = 0;   // wrong values
    int proto_errs = 0;   // ordering and timeout problems

    // model state
    timestamp_t cyc;          // mirrors the timestamp counter
    trig_num_t  trig_cnt;     // last accepted number
    trig_num_t  ev_cnt;
    trig_info_t exp_q[$];     // expected readouts
    logic       issue_pend, rate_exp, rr_prev, dones_seen, acq_active, cm_busy;
    chan_mask_t acq_mask;
    timestamp_t acq_trig_cyc, acq_start;
    int         acqs_done, readouts, accepted, dropped;

    tb_clock_gen clk_i (.clk(ttc_clk), .arst_n(arst_n));

    trigger_top #(.FIFO_DEPTH(16)) dut_i (.*);

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic num_check(input string name, input trig_num_t got, input trig_num_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic type_check(input string name, input trig_type_t got, input trig_type_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic stamp_check(input string name, input timestamp_t got, input timestamp_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic mask_check(input string name, input chan_mask_t got, input chan_mask_t exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model, sampled at the rising edge
    // ------------------------------------------------------------------------
    always @(posedge ttc_clk) begin
        logic       accept;
        trig_info_t rec;
        if (arst_n) begin
            mask_check("chan_trig", chan_trig,
                       (acq_active && cyc == acq_trig_cyc) ? acq_mask : '0);
            if (acq_active && cyc >= acq_start) begin
                if (chan_enable == '0) begin  // record written, back in idle
                    if (!dones_seen) begin
                        $display("chan_enable dropped before all dones were seen");
                        proto_errs++;
                    end
                    acq_active = 1'b0;
                    acqs_done++;
                end else begin
                    mask_check("chan_enable", chan_enable, acq_mask);
                    if (cyc > acq_trig_cyc && (chan_dones & acq_mask) == acq_mask)
                        dones_seen = 1'b1;
                end
            end
            flag_check("error_trig_rate", error_trig_rate, rate_exp);
            flag_check("error_trig_num", error_trig_num, 1'b0);
            flag_check("error_trig_type", error_trig_type, 1'b0);
            flag_check("trig_fifo_full", trig_fifo_full, 1'b0);

            if (initiate_readout) begin
                if (!rr_prev) begin
                    $display("readout started while readout_ready was low");
                    proto_errs++;
                end
                if (readouts >= acqs_done) begin
                    $display("readout started before the acquisition finished");
                    proto_errs++;
                end
                if (exp_q.size() == 0) begin
                    $display("readout started with no trigger outstanding");
                    proto_errs++;
                end else begin
                    rec = exp_q.pop_front();
                    ev_cnt++;
                    num_check("ttc_trig_num", ttc_trig_num, rec.trig_num);
                    type_check("ttc_trig_type", ttc_trig_type, rec.trig_type);
                    stamp_check("ttc_trig_timestamp", ttc_trig_timestamp, rec.timestamp);
                    num_check("ttc_event_num", ttc_event_num, ev_cnt);
                end
                readouts++;
            end

            // request lands this cycle, controller captures mask and delay
            if (issue_pend) begin
                acq_active   = 1'b1;
                dones_seen   = 1'b0;
                acq_mask     = chan_en;
                acq_trig_cyc = cyc + trig_delay + 1;  // delay + 2 after the sample
                acq_start    = cyc + 1;
            end

            accept = ttc_trigger && !issue_pend && (chan_enable == '0) && !acq_active;
            if (rst_trigger_num)
                trig_cnt = '0;
            if (accept) begin
                trig_cnt++;
                rec.timestamp = cyc;
                rec.trig_num  = trig_cnt;
                rec.trig_type = trig_type;
                exp_q.push_back(rec);
                accepted++;
            end else if (ttc_trigger) begin
                rate_exp = 1'b1;  // dropped
                dropped++;
            end
            issue_pend = accept;
            rr_prev    = readout_ready;
            cyc++;
        end
    end

    // channel model: dones a few cycles after the trigger, held until released
    always @(posedge ttc_clk) begin
        int         cnt;
        chan_mask_t m;
        if (arst_n) begin
            if (chan_trig != '0) begin
                m   = chan_trig;
                cnt = 1 + ($unsigned($random(seed)) % 8);
            end else if (cnt > 0) begin
                cnt--;
                if (cnt == 0)
                    chan_dones <= m;
            end
            if (chan_enable == '0 && chan_dones != '0)
                chan_dones <= '0;
        end
    end

    // command manager model
    always @(posedge ttc_clk) begin
        int wait_cnt;
        readout_done <= 1'b0;
        if (arst_n) begin
            if (initiate_readout) begin
                cm_busy       = 1'b1;
                readout_ready <= 1'b0;
                wait_cnt      = 1 + ($unsigned($random(seed)) % 10);
            end else if (cm_busy) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    readout_done <= 1'b1;
                    cm_busy = 1'b0;
                end
            end else begin
                readout_ready <= ($unsigned($random(seed)) % 4) != 0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        int t;
        {ttc_trigger, rst_trigger_num, rst_trigger_timestamp} = '0;
        trig_type     = '0;
        chan_en       = '0;
        trig_delay    = '0;
        chan_dones    = '0;
        readout_ready = 1'b0;
        readout_done  = 1'b0;
        cyc      = '0;
        trig_cnt = '0;
        ev_cnt   = '0;
        {issue_pend, rate_exp, rr_prev, dones_seen, acq_active, cm_busy} = '0;
        acq_mask     = '0;
        acq_trig_cyc = '0;
        acq_start    = '0;
        {acqs_done, readouts, accepted, dropped} = '0;

        t = 0;
        while (!arst_n && t < 100) begin
            @(negedge ttc_clk);
            t++;
        end
        if (!arst_n) begin
            $display("reset never released");
            proto_errs++;
        end
        // control outputs quiet after reset
        mask_check("chan_enable", chan_enable, '0);
        mask_check("chan_trig", chan_trig, '0);
        flag_check("initiate_readout", initiate_readout, 1'b0);
        flag_check("acq_fifo_full", acq_fifo_full, 1'b0);

        for (int i = 0; i < RUN_CYCLES; i++) begin
            @(posedge ttc_clk);
            if (i == RUN_CYCLES / 2) begin
                ttc_trigger     <= 1'b0;  // number reset on a quiet cycle
                rst_trigger_num <= 1'b1;
            end else begin
                rst_trigger_num <= 1'b0;
                ttc_trigger     <= ($unsigned($random(seed)) % 6) == 0;
            end
            trig_type  <= $random(seed);
            chan_en    <= $random(seed) | 5'h01;
            trig_delay <= $unsigned($random(seed)) % 8;
        end
        @(posedge ttc_clk);
        ttc_trigger     <= 1'b0;
        rst_trigger_num <= 1'b0;

        // drain outstanding events
        t = 0;
        while ((exp_q.size() != 0 || acq_active || cm_busy) && t < WAIT_LIMIT) begin
            @(posedge ttc_clk);
            t++;
        end
        if (t >= WAIT_LIMIT) begin
            $display("timeout waiting for outstanding readouts");
            proto_errs++;
        end
        if (accepted == 0 || dropped == 0) begin
            $display("stimulus did not exercise both accepted and dropped triggers");
            proto_errs++;
        end
        repeat (3) @(posedge ttc_clk);

        $display("accepted %0d dropped %0d readouts %0d value errors %0d protocol errors %0d",
                 accepted, dropped, readouts, value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // run limit
    initial begin
        #((RUN_CYCLES + WAIT_LIMIT + 200) * 4);
        $display("simulation ran past its limit");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
// testbench only; 4 ns clock, reset held low for 5 cycles and released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS   = 4.0,
    parameter int  RST_CYCLES  = 5
) (
    output logic clk,
    output logic arst_n
);
    initial clk = 1'b0;
    always #(PERIOD_NS / 2.0) clk = ~clk;  // free running

    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // away from the sampling edge
    end

endmodule

`default_nettype wire

//--- hdl/trigger_top.sv
// single ttc_clk domain; chan_dones, readout_ready and readout_done must arrive synchronous to it
`timescale 1ns/1ps
`default_nettype none

module trigger_top #(
    parameter int FIFO_DEPTH = 16  // both event fifos
) (
    input  wire                             ttc_clk,
    input  wire                             arst_n,
    input  wire                             rst_trigger_num,        // ttc channel b
    input  wire                             rst_trigger_timestamp,  // ttc channel b
    input  wire                             ttc_trigger,
    input  wire trigger_pkg::trig_type_t    trig_type,
    input  wire trigger_pkg::chan_mask_t    chan_en,
    input  wire [trigger_pkg::DELAY_W-1:0]  trig_delay,
    input  wire trigger_pkg::chan_mask_t    chan_dones,
    output trigger_pkg::chan_mask_t         chan_enable,
    output trigger_pkg::chan_mask_t         chan_trig,
    input  wire                             readout_ready,
    input  wire                             readout_done,
    output logic                            initiate_readout,
    output trigger_pkg::trig_num_t          ttc_event_num,
    output trigger_pkg::trig_num_t          ttc_trig_num,
    output trigger_pkg::trig_type_t         ttc_trig_type,
    output trigger_pkg::timestamp_t         ttc_trig_timestamp,
    output logic                            trig_fifo_full,  // almost full
    output logic                            acq_fifo_full,   // almost full
    output logic                            error_trig_rate,
    output logic                            error_trig_num,
    output logic                            error_trig_type
);
    import trigger_pkg::*;

    // -----------------------------------------------------------------------
    // internal connections
    // -----------------------------------------------------------------------
    acq_req_if  req ();  // stamper to controller

    logic       trig_wr_valid, trig_wr_ready, trig_rd_valid, trig_rd_ready;
    trig_info_t trig_wr_data, trig_rd_data;
    logic       acq_wr_valid, acq_wr_ready, acq_rd_valid, acq_rd_ready;
    acq_event_t acq_wr_data, acq_rd_data;

    // -----------------------------------------------------------------------
    // instances
    // -----------------------------------------------------------------------
    trigger_stamper stamper_i (
        .ttc_clk, .arst_n, .ttc_trigger, .trig_type, .rst_trigger_num,
        .rst_trigger_timestamp, .req(req.stamper),
        .fifo_wr_valid(trig_wr_valid), .fifo_wr_ready(trig_wr_ready),
        .fifo_wr_data(trig_wr_data), .error_trig_rate
    );

    acq_controller controller_i (
        .ttc_clk, .arst_n, .req(req.controller), .chan_en, .chan_dones, .trig_delay,
        .chan_enable, .chan_trig, .fifo_wr_valid(acq_wr_valid),
        .fifo_wr_ready(acq_wr_ready), .fifo_wr_data(acq_wr_data)
    );

    // trigger info records
    event_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(trig_info_t)) trig_fifo_i (
        .ttc_clk, .arst_n, .wr_valid(trig_wr_valid), .wr_ready(trig_wr_ready),
        .wr_data(trig_wr_data), .rd_valid(trig_rd_valid), .rd_ready(trig_rd_ready),
        .rd_data(trig_rd_data), .almost_full(trig_fifo_full)
    );

    // acquisition event records
    event_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(acq_event_t)) acq_fifo_i (
        .ttc_clk, .arst_n, .wr_valid(acq_wr_valid), .wr_ready(acq_wr_ready),
        .wr_data(acq_wr_data), .rd_valid(acq_rd_valid), .rd_ready(acq_rd_ready),
        .rd_data(acq_rd_data), .almost_full(acq_fifo_full)
    );

    event_matcher matcher_i (
        .ttc_clk, .arst_n, .trig_rd_valid, .trig_rd_data, .trig_rd_ready,
        .acq_rd_valid, .acq_rd_data, .acq_rd_ready, .readout_ready, .readout_done,
        .initiate_readout, .ttc_event_num, .ttc_trig_num, .ttc_trig_type,
        .ttc_trig_timestamp, .error_trig_num, .error_trig_type
    );

endmodule

`default_nettype wire

//--- hdl/event_matcher.sv
// readout_done is only honoured after initiate_readout; mismatch flags stay set until reset
`timescale 1ns/1ps
`default_nettype none

module event_matcher (
    input  wire                          ttc_clk,
    input  wire                          arst_n,
    input  wire                          trig_rd_valid,
    input  wire trigger_pkg::trig_info_t trig_rd_data,
    output logic                         trig_rd_ready,
    input  wire                          acq_rd_valid,
    input  wire trigger_pkg::acq_event_t acq_rd_data,
    output logic                         acq_rd_ready,
    input  wire                          readout_ready,  // command manager idle
    input  wire                          readout_done,   // one-cycle pulse
    output logic                         initiate_readout,
    output trigger_pkg::trig_num_t       ttc_event_num,
    output trigger_pkg::trig_num_t       ttc_trig_num,
    output trigger_pkg::trig_type_t      ttc_trig_type,
    output trigger_pkg::timestamp_t      ttc_trig_timestamp,
    output logic                         error_trig_num,
    output logic                         error_trig_type
);
    import trigger_pkg::*;

    typedef enum logic {
        M_IDLE,
        M_BUSY   // readout in progress
    } mstate_t;

    mstate_t state;
    logic    pop;

    // both records leave their fifos together
    assign pop           = (state == M_IDLE) & trig_rd_valid & acq_rd_valid & readout_ready;
    assign trig_rd_ready = pop;
    assign acq_rd_ready  = pop;

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            state            <= M_IDLE;
            initiate_readout <= 1'b0;
            ttc_event_num    <= '0;
            error_trig_num   <= 1'b0;
            error_trig_type  <= 1'b0;
        end else begin
            initiate_readout <= pop;  // one cycle after the pop
            if (pop) begin
                state         <= M_BUSY;
                ttc_event_num <= ttc_event_num + 1'b1;  // first event is 1
                if (trig_rd_data.trig_num != acq_rd_data.trig_num)
                    error_trig_num <= 1'b1;
                if (trig_rd_data.trig_type != acq_rd_data.trig_type)
                    error_trig_type <= 1'b1;
            end else if (state == M_BUSY && readout_done) begin
                state <= M_IDLE;
            end
        end
    end

    // event outputs held until the next pop
    always_ff @(posedge ttc_clk) begin
        if (pop) begin
            ttc_trig_num       <= trig_rd_data.trig_num;
            ttc_trig_type      <= trig_rd_data.trig_type;
            ttc_trig_timestamp <= trig_rd_data.timestamp;
        end
    end

    a_init_pulse : assert property (@(posedge ttc_clk) disable iff (!arst_n)
        initiate_readout |=> !initiate_readout)
        else $error("initiate_readout held for two cycles");

endmodule

`default_nettype wire

//--- hdl/event_fifo.sv
// first-word-fall-through; a write to a full fifo is ignored since wr_ready is low
`timescale 1ns/1ps
`default_nettype none

module event_fifo #(
    parameter int  FIFO_DEPTH = 16,
    parameter type payload_t  = logic [7:0]
) (
    input  wire           ttc_clk,
    input  wire           arst_n,
    input  wire           wr_valid,
    output logic          wr_ready,
    input  wire payload_t wr_data,
    output logic          rd_valid,
    input  wire           rd_ready,
    output payload_t      rd_data,
    output logic          almost_full  // depth - 1 or more
);
    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    payload_t        mem [FIFO_DEPTH];
    logic [AW-1:0]   wr_ptr, rd_ptr;
    logic [CW-1:0]   count;  // occupancy
    logic            do_wr, do_rd;

    assign do_wr = wr_valid & wr_ready;
    assign do_rd = rd_valid & rd_ready;

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    // storage
    always_ff @(posedge ttc_clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    assign wr_ready    = (count != CW'(FIFO_DEPTH));
    assign rd_valid    = (count != '0);
    assign rd_data     = mem[rd_ptr];  // head word shows without a read
    assign almost_full = (count >= CW'(FIFO_DEPTH - 1));

    a_no_overflow : assert property (@(posedge ttc_clk) disable iff (!arst_n)
        count <= CW'(FIFO_DEPTH))
        else $error("fifo occupancy above depth");

endmodule

`default_nettype wire

//--- hdl/acq_controller.sv
// chan_dones must stay high until sampled; channels masked off at the request are not waited on
`timescale 1ns/1ps
`default_nettype none

module acq_controller (
    input  wire                                 ttc_clk,
    input  wire                                 arst_n,
    acq_req_if.controller                       req,
    input  wire trigger_pkg::chan_mask_t        chan_en,     // sampled at request
    input  wire trigger_pkg::chan_mask_t        chan_dones,
    input  wire [trigger_pkg::DELAY_W-1:0]      trig_delay,  // sampled at request
    output trigger_pkg::chan_mask_t             chan_enable,
    output trigger_pkg::chan_mask_t             chan_trig,
    output logic                                fifo_wr_valid,
    input  wire                                 fifo_wr_ready,
    output trigger_pkg::acq_event_t             fifo_wr_data
);
    import trigger_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_DELAY,   // count down trig_delay
        S_TRIG,    // chan_trig pulse
        S_WAIT,    // wait on dones
        S_WRITE    // push acquisition record
    } state_t;

    state_t              state;
    logic [DELAY_W-1:0]  delay_cnt;
    chan_mask_t          mask_q;     // captured chan_en
    trig_num_t           trig_num_q;
    trig_type_t          trig_type_q;

    // -----------------------------------------------------------------------
    // fsm
    // -----------------------------------------------------------------------
    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            delay_cnt <= '0;
            mask_q    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req.trigger) begin
                        mask_q    <= chan_en;
                        delay_cnt <= trig_delay - 1'b1;  // unused when delay is 0
                        state     <= (trig_delay == '0) ? S_TRIG : S_DELAY;
                    end
                end
                S_DELAY: begin
                    if (delay_cnt == '0)
                        state <= S_TRIG;
                    else
                        delay_cnt <= delay_cnt - 1'b1;
                end
                S_TRIG:  state <= S_WAIT;
                S_WAIT: begin
                    if ((chan_dones & mask_q) == mask_q)
                        state <= S_WRITE;  // all enabled channels done
                end
                S_WRITE: begin
                    if (fifo_wr_ready)
                        state <= S_IDLE;   // back-pressure holds us here
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // number and type ride along to the record
    always_ff @(posedge ttc_clk) begin
        if (state == S_IDLE && req.trigger) begin
            trig_num_q  <= req.trig_num;
            trig_type_q <= req.trig_type;
        end
    end

    // -----------------------------------------------------------------------
    // outputs
    // -----------------------------------------------------------------------
    assign req.acq_ready          = (state == S_IDLE);
    assign chan_enable            = (state != S_IDLE) ? mask_q : '0;
    assign chan_trig              = (state == S_TRIG) ? mask_q : '0;  // delay + 2 after trigger
    assign fifo_wr_valid          = (state == S_WRITE);
    assign fifo_wr_data.trig_num  = trig_num_q;
    assign fifo_wr_data.trig_type = trig_type_q;

    // chan_en at the request shows on chan_enable next cycle and bounds chan_trig
    a_trig_in_mask : assert property (@(posedge ttc_clk) disable iff (!arst_n)
        (req.acq_ready && req.trigger) |=> ((chan_enable == $past(chan_en))
            && ((chan_trig & ~$past(chan_en)) == '0)))
        else $error("chan_trig outside captured mask");

endmodule

`default_nettype wire

//--- hdl/trigger_stamper.sv
// one trigger accepted per controller cycle; counters wrap silently at full width
`timescale 1ns/1ps
`default_nettype none

module trigger_stamper (
    input  wire                          ttc_clk,
    input  wire                          arst_n,
    input  wire                          ttc_trigger,            // ttc trigger sample
    input  wire trigger_pkg::trig_type_t trig_type,
    input  wire                          rst_trigger_num,        // ttc channel b
    input  wire                          rst_trigger_timestamp,  // ttc channel b
    acq_req_if.stamper                   req,
    output logic                         fifo_wr_valid,
    input  wire                          fifo_wr_ready,
    output trigger_pkg::trig_info_t      fifo_wr_data,
    output logic                         error_trig_rate         // sticky
);
    import trigger_pkg::*;

    timestamp_t timestamp_cnt;  // free running
    trig_num_t  trig_num_cnt;   // last accepted number
    logic       issue_q;        // request + fifo write this cycle
    trig_info_t info_q;
    logic       accept;

    // busy while the previous request is still on the wire
    assign accept = ttc_trigger & req.acq_ready & fifo_wr_ready & ~issue_q;

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            timestamp_cnt   <= '0;
            trig_num_cnt    <= '0;
            issue_q         <= 1'b0;
            error_trig_rate <= 1'b0;
        end else begin
            if (rst_trigger_timestamp)
                timestamp_cnt <= '0;
            else
                timestamp_cnt <= timestamp_cnt + 1'b1;

            if (rst_trigger_num)
                trig_num_cnt <= '0;
            else if (accept)
                trig_num_cnt <= trig_num_cnt + 1'b1;

            issue_q <= accept;

            if (ttc_trigger && !accept)
                error_trig_rate <= 1'b1;  // dropped trigger
        end
    end

    // record for the accepted trigger
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            info_q.timestamp <= timestamp_cnt;
            info_q.trig_num  <= trig_num_cnt + 1'b1;  // first is 1
            info_q.trig_type <= trig_type;
        end
    end

    assign req.trigger   = issue_q;
    assign req.trig_type = info_q.trig_type;
    assign req.trig_num  = info_q.trig_num;
    assign fifo_wr_valid = issue_q;  // same cycle as the request
    assign fifo_wr_data  = info_q;

    // controller must still be idle when the request lands
    a_req_when_ready : assert property (@(posedge ttc_clk) disable iff (!arst_n)
        req.trigger |-> req.acq_ready)
        else $error("request issued while controller busy");

endmodule

`default_nettype wire

//--- hdl/acq_req_if.sv
// single request in flight; trigger may only pulse while the controller reports acq_ready
`timescale 1ns/1ps
`default_nettype none

interface acq_req_if;
    import trigger_pkg::*;

    logic       trigger;    // one-cycle request pulse
    trig_type_t trig_type;  // valid with trigger
    trig_num_t  trig_num;   // valid with trigger
    logic       acq_ready;  // controller sits in idle

    // stamper side
    modport stamper (
        output trigger,
        output trig_type,
        output trig_num,
        input  acq_ready
    );

    // controller side
    modport controller (
        input  trigger,
        input  trig_type,
        input  trig_num,
        output acq_ready
    );

endinterface

`default_nettype wire

//--- hdl/trigger_pkg.sv
// widths fixed for five channels and 44-bit timestamps; record layouts must match the readout side
`default_nettype none

package trigger_pkg;

    // -----------------------------------------------------------------------
    // widths
    // -----------------------------------------------------------------------
    localparam int NUM_CHAN    = 5;   // channel fpgas
    localparam int TRIG_NUM_W  = 24;  // global trigger number
    localparam int TIMESTAMP_W = 44;  // free running ttc_clk count
    localparam int TRIG_TYPE_W = 5;   // muon fill, laser, pedestal ...
    localparam int DELAY_W     = 16;  // trigger to channel delay in cycles

    // -----------------------------------------------------------------------
    // basic types
    // -----------------------------------------------------------------------
    typedef logic [TRIG_NUM_W-1:0]  trig_num_t;
    typedef logic [TIMESTAMP_W-1:0] timestamp_t;
    typedef logic [TRIG_TYPE_W-1:0] trig_type_t;
    typedef logic [NUM_CHAN-1:0]    chan_mask_t;  // one bit per channel

    // trigger fifo payload, 73 bits
    typedef struct packed {
        timestamp_t timestamp;  // stamp at acceptance
        trig_num_t  trig_num;   // starts at 1
        trig_type_t trig_type;
    } trig_info_t;

    // acquisition fifo payload, 29 bits
    typedef struct packed {
        trig_num_t  trig_num;
        trig_type_t trig_type;
    } acq_event_t;

endpackage

`default_nettype wire
